// File: source/lsu_defs.svh
// lsu width and exception-code definitions shared by the load/store unit
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath widths
`define LSU_DATA_W  32      // one sram word
`define LSU_ADDR_W  32      // byte address
`define LSU_REG_W   5       // register-file index

// mapping keeps the low bits only
// top three bits cleared, so kseg0/kseg1 alias onto the physical window
`define LSU_PHYS_W  29

// address-error exception codes, cp0 cause encoding
`define LSU_EXC_W     5
`define LSU_EXC_ADEL  5'h04 // load or fetch from misaligned address
`define LSU_EXC_ADES  5'h05 // store to misaligned address

`endif

// File: source/lsu_pkg.sv
// lsu types: access size, request and stage records, sram word lane view
`include "lsu_defs.svh"

`default_nettype none

package lsu_pkg;

    // same encoding the pipeline decoder hands down
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    // one memory request, valid for the cycle it is presented
    typedef struct packed {
        logic                   valid;       // request strobe
        logic                   is_store;    // 0 means load
        mem_size_e              size;
        logic                   is_unsigned; // lbu / lhu
        logic [`LSU_ADDR_W-1:0] addr;        // virtual byte address
        logic [`LSU_DATA_W-1:0] wdata;       // store data, right aligned
        logic [`LSU_REG_W-1:0]  rd;          // load destination
    } lsu_req_t;

    // what the memory stage passes to write-back
    typedef struct packed {
        logic                   valid;
        logic                   is_load;
        mem_size_e              size;
        logic                   is_unsigned;
        logic [1:0]             addr_lo;     // lane select for extraction
        logic [`LSU_ADDR_W-1:0] bad_addr;    // unmapped address, for badvaddr
        logic                   exc;         // misaligned access seen
        logic [`LSU_EXC_W-1:0]  exc_code;
        logic [`LSU_REG_W-1:0]  rd;
    } lsu_stage_t;

    // sram word, seen as bytes or as halfwords
    typedef union packed {
        logic [`LSU_DATA_W/8-1:0][7:0]   b;  // b[0] is the lowest address
        logic [`LSU_DATA_W/16-1:0][15:0] h;
    } lsu_word_u;

endpackage

`default_nettype wire

// File: source/mem_access.sv
// memory stage: address mapping, store lane placement, byte enables, alignment check
`include "lsu_defs.svh"

`default_nettype none

module mem_access (
    input  lsu_pkg::lsu_req_t       req,
    output logic                    data_sram_en,    // sram enable, high active
    output logic [3:0]              data_sram_wen,   // byte write enables
    output logic [`LSU_ADDR_W-1:0]  data_sram_addr,  // byte address
    output logic [`LSU_DATA_W-1:0]  data_sram_wdata,
    output lsu_pkg::lsu_stage_t     stage_next       // to write-back register
);
    import lsu_pkg::*;

    logic       misaligned;
    logic [1:0] ofs;        // byte offset inside the word
    logic [3:0] be;         // lane enables before the store qualifier
    lsu_word_u  wword;      // store word after lane placement

    assign ofs = req.addr[1:0];

    // word needs 1:0 clear, half needs bit 0 clear
    always_comb
    begin
        case (req.size)
            MEM_WORD: misaligned = (ofs != 2'b00);
            MEM_HALF: misaligned = ofs[0];
            default:  misaligned = 1'b0;       // byte never faults
        endcase
    end

    // move store data into the lanes its offset selects, other lanes zero
    always_comb
    begin
        wword = '0;
        be    = 4'b0000;
        case (req.size)
            MEM_WORD:
            begin
                wword = req.wdata;             // full word, no shift
                be    = 4'b1111;
            end
            MEM_HALF:
            begin
                wword.h[ofs[1]] = req.wdata[15:0];
                be              = ofs[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wword.b[ofs] = req.wdata[7:0];
                be           = 4'b0001 << ofs; // one lane
            end
        endcase
    end

    // sram drive, same cycle as the request
    assign data_sram_en    = req.valid && !misaligned; // faulting access never reaches memory
    assign data_sram_wen   = (data_sram_en && req.is_store) ? be : 4'b0000;
    assign data_sram_addr  = {{(`LSU_ADDR_W-`LSU_PHYS_W){1'b0}}, req.addr[`LSU_PHYS_W-1:0]};
    assign data_sram_wdata = wword;

    // hand-off to write-back
    always_comb
    begin
        stage_next.valid       = req.valid;
        stage_next.is_load     = !req.is_store;
        stage_next.size        = req.size;
        stage_next.is_unsigned = req.is_unsigned;
        stage_next.addr_lo     = ofs;
        stage_next.bad_addr    = req.addr;             // unmapped, as software sees it
        stage_next.exc         = req.valid && misaligned;
        stage_next.exc_code    = req.is_store ? `LSU_EXC_ADES : `LSU_EXC_ADEL;
        stage_next.rd          = req.rd;
    end

    // placed store bytes stay inside the enabled lanes
    always_comb
    begin
        a_wdata_in_lanes: assert (
            (data_sram_wdata & ~{{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}}) == 32'h0
        ) else $error("store data outside the enabled byte lanes");
    end

endmodule

`default_nettype wire

// File: source/load_extract.sv
// write-back stage: stage register, load lane select and extension, exception report
`include "lsu_defs.svh"

`default_nettype none

module load_extract (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_pkg::lsu_stage_t    stage_next,
    input  logic [`LSU_DATA_W-1:0] data_sram_rdata, // one cycle after the access
    output logic                   wb_rf_wen,
    output logic [`LSU_REG_W-1:0]  wb_rf_wnum,
    output logic [`LSU_DATA_W-1:0] wb_rf_wdata,
    output logic                   wb_exc,          // one-cycle pulse
    output logic [`LSU_EXC_W-1:0]  wb_exc_code,
    output logic [`LSU_ADDR_W-1:0] wb_bad_addr
);
    import lsu_pkg::*;

    lsu_stage_t             stage_q;   // mem/wb pipeline register
    lsu_word_u              rword;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;
    logic                   sext;      // sign bit replication enable
    logic [`LSU_DATA_W-1:0] load_data;
    logic                   lane_ok;   // stored offset fits the size

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            stage_q <= '0;             // no write or exception out of reset
        else
            stage_q <= stage_next;
    end

    assign rword    = data_sram_rdata;
    assign sel_byte = rword.b[stage_q.addr_lo];    // lane named by offset
    assign sel_half = rword.h[stage_q.addr_lo[1]]; // bit 0 is zero when aligned
    assign sext     = !stage_q.is_unsigned;

    // extend selected lane to a full register
    always_comb
    begin
        case (stage_q.size)
            MEM_WORD: load_data = rword;
            MEM_HALF: load_data = {{(`LSU_DATA_W-16){sext & sel_half[15]}}, sel_half};
            default:  load_data = {{(`LSU_DATA_W-8){sext & sel_byte[7]}}, sel_byte};
        endcase
    end

    // alignment of the stored offset for its size
    always_comb
    begin
        case (stage_q.size)
            MEM_WORD: lane_ok = (stage_q.addr_lo == 2'b00);
            MEM_HALF: lane_ok = !stage_q.addr_lo[0];
            default:  lane_ok = 1'b1;
        endcase
    end

    // stores and faulting loads write nothing
    assign wb_rf_wen   = stage_q.valid && stage_q.is_load && !stage_q.exc;
    assign wb_rf_wnum  = stage_q.rd;
    assign wb_rf_wdata = load_data;

    // reported only, the pipeline is not redirected here
    assign wb_exc      = stage_q.valid && stage_q.exc;
    assign wb_exc_code = stage_q.exc_code;
    assign wb_bad_addr = stage_q.bad_addr;

    // lane select relies on misaligned offsets being trapped upstream
    a_wen_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rf_wen |-> lane_ok
    ) else $error("register write from a misaligned access");

    // exception only for a true misalignment, so never with a register write
    a_exc_misaligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_exc |-> !lane_ok
    ) else $error("exception reported for an aligned access");

endmodule

`default_nettype wire

// File: source/lsu_top.sv
// load/store unit top: memory stage and write-back stage on the data sram
`include "lsu_defs.svh"

`default_nettype none

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_pkg::lsu_req_t      req,             // one request per cycle
    output logic                   data_sram_en,
    output logic [3:0]             data_sram_wen,
    output logic [`LSU_ADDR_W-1:0] data_sram_addr,
    output logic [`LSU_DATA_W-1:0] data_sram_wdata,
    input  logic [`LSU_DATA_W-1:0] data_sram_rdata,
    output logic                   wb_rf_wen,
    output logic [`LSU_REG_W-1:0]  wb_rf_wnum,
    output logic [`LSU_DATA_W-1:0] wb_rf_wdata,
    output logic                   wb_exc,
    output logic [`LSU_EXC_W-1:0]  wb_exc_code,
    output logic [`LSU_ADDR_W-1:0] wb_bad_addr
);
    import lsu_pkg::*;

    lsu_stage_t stage_next;  // mem to wb

    // zero latency, drives sram directly
    mem_access u_mem_access (
        .req             (req),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .stage_next      (stage_next)
    );

    // one register stage, meets rdata from sram
    load_extract u_load_extract (
        .clk             (clk),
        .rst_n           (rst_n),
        .stage_next      (stage_next),
        .data_sram_rdata (data_sram_rdata),
        .wb_rf_wen       (wb_rf_wen),
        .wb_rf_wnum      (wb_rf_wnum),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_exc          (wb_exc),
        .wb_exc_code     (wb_exc_code),
        .wb_bad_addr     (wb_bad_addr)
    );

endmodule

`default_nettype wire

// File: verification/tb_sram_model.sv
// data sram model: byte write enables, registered read with one cycle latency
`default_nettype none

module tb_sram_model (
    input  logic        clk,
    input  logic        en,
    input  logic [3:0]  wen,    // one bit per byte lane
    input  logic [31:0] addr,   // byte address, low two bits ignored
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [logic [29:0]];  // sparse, word addressed
    logic [31:0] cur;

    // never written words read back a pattern of their own address
    function automatic logic [31:0] fill_word(input logic [29:0] wa);
        return {wa, 2'b11} ^ 32'hc3a5_5a3c;
    endfunction

    always @(posedge clk)
    begin
        if (en)
        begin
            cur   = mem.exists(addr[31:2]) ? mem[addr[31:2]] : fill_word(addr[31:2]);
            rdata <= cur;  // old contents on a write
            for (int i = 0; i < 4; i++)
                if (wen[i])
                    cur[8*i +: 8] = wdata[8*i +: 8];
            if (wen != 4'b0000)
                mem[addr[31:2]] = cur;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_lsu.sv
// load/store unit testbench: stimulus, reference memory, concurrent checks and summary
`include "lsu_defs.svh"

`default_nettype none

module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int N_RAND      = 300;
    localparam int N_FIXED     = 100;  // upper bound on directed requests and idle cycles
    localparam int WATCHDOG_NS = (N_FIXED + N_RAND) * 20 + 2000;

    logic                   clk;
    logic                   rst_n;
    lsu_req_t               req;        // request of the current cycle
    lsu_req_t               prev_req;   // request now in write-back
    logic                   data_sram_en;
    logic [3:0]             data_sram_wen;
    logic [`LSU_ADDR_W-1:0] data_sram_addr;
    logic [`LSU_DATA_W-1:0] data_sram_wdata;
    logic [`LSU_DATA_W-1:0] data_sram_rdata;
    logic                   wb_rf_wen;
    logic [`LSU_REG_W-1:0]  wb_rf_wnum;
    logic [`LSU_DATA_W-1:0] wb_rf_wdata;
    logic                   wb_exc;
    logic [`LSU_EXC_W-1:0]  wb_exc_code;
    logic [`LSU_ADDR_W-1:0] wb_bad_addr;

    logic [31:0] shadow [logic [31:0]]; // words as written, keyed by mapped address
    logic [31:0] exp_load;              // expected load result of prev_req
    logic [31:0] next_load;             // same for req
    logic        req_ok;
    logic        prev_ok;
    logic        prev_load;
    logic        prev_fault;
    logic [3:0]  exp_wen;
    logic [4:0]  exp_code;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int          n_req = 0;
    string       test_name = "reset";

    lsu_top dut (.*);

    tb_sram_model sram (
        .clk   (clk),
        .en    (data_sram_en),
        .wen   (data_sram_wen),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

    always #10 clk = ~clk;

    function automatic logic is_aligned(input lsu_req_t r);
        case (r.size)
            MEM_WORD: return r.addr[1:0] == 2'b00;
            MEM_HALF: return !r.addr[0];
            default:  return 1'b1;
        endcase
    endfunction

    function automatic logic [3:0] lane_mask(input lsu_req_t r);
        case (r.size)
            MEM_WORD: return 4'b1111;
            MEM_HALF: return r.addr[1] ? 4'b1100 : 4'b0011;
            default:  return 4'b0001 << r.addr[1:0];
        endcase
    endfunction

    // store data shifted up to its offset, unused lanes zero
    function automatic logic [31:0] placed_data(input lsu_req_t r);
        case (r.size)
            MEM_WORD: return r.wdata;
            MEM_HALF: return {16'h0, r.wdata[15:0]} << (8 * r.addr[1:0]);
            default:  return {24'h0, r.wdata[7:0]} << (8 * r.addr[1:0]);
        endcase
    endfunction

    function automatic logic [31:0] mapped(input logic [31:0] a);
        return a & 32'h1fff_ffff;  // top three bits dropped
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word, input lsu_req_t r);
        logic [31:0] sh;
        sh = word >> (8 * r.addr[1:0]);
        case (r.size)
            MEM_WORD: return word;
            MEM_HALF: return r.is_unsigned ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default:  return r.is_unsigned ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
        endcase
    endfunction

    // 16 words in one physical region, random segment bits on top
    function automatic logic [31:0] pool_addr(input int w, input int o);
        logic [31:0] a;
        a       = $urandom;
        a[28:6] = 23'h15_a3c7;
        a[5:2]  = 4'(w);
        a[1:0]  = 2'(o);
        return a;
    endfunction

    function automatic lsu_req_t make_req(input logic st, input mem_size_e sz, input logic uns,
                                          input logic [31:0] a, input logic [31:0] d);
        lsu_req_t r;
        r             = '0;
        r.valid       = 1'b1;
        r.is_store    = st;
        r.size        = sz;
        r.is_unsigned = uns;
        r.addr        = a;
        r.wdata       = d;
        r.rd          = 5'($urandom);
        return r;
    endfunction

    task automatic log_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        mismatch_cnt++;
        $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic note_failure(input string what);
        fail_cnt++;
        $display("error in %s: %s", test_name, what);
    endtask

    // merge the store lanes into the reference word
    task automatic store_shadow(input lsu_req_t r);
        logic [31:0] key;
        logic [31:0] word;
        logic [3:0]  m;
        logic [31:0] d;
        key  = mapped(r.addr) & 32'hffff_fffc;
        word = shadow.exists(key) ? shadow[key] : 32'h0;
        m    = lane_mask(r);
        d    = placed_data(r);
        for (int i = 0; i < 4; i++)
            if (m[i])
                word[8*i +: 8] = d[8*i +: 8];
        shadow[key] = word;
    endtask

    // drive one request after the rising edge, previous one moves to write-back
    task automatic send(input lsu_req_t r);
        logic [31:0] key;
        @(posedge clk);
        #2;
        prev_req = req;
        exp_load = next_load;
        req      = r;
        key      = mapped(r.addr) & 32'hffff_fffc;
        if (r.valid && is_aligned(r))
        begin
            if (r.is_store)
                store_shadow(r);
            else if (shadow.exists(key))
                next_load = extend_load(shadow[key], r);
            else
                note_failure("load from a word the testbench never wrote");
        end
        n_req++;
    endtask

    assign req_ok     = is_aligned(req);
    assign prev_ok    = is_aligned(prev_req);
    assign prev_load  = prev_req.valid && !prev_req.is_store && prev_ok;
    assign prev_fault = prev_req.valid && !prev_ok;
    assign exp_wen    = (req.valid && req_ok && req.is_store) ? lane_mask(req) : 4'b0000;
    assign exp_code   = prev_req.is_store ? 5'd5 : 5'd4;  // ades for stores, adel for loads

    // checked mid cycle, all inputs and registers settled
    a_sram_en: assert property (@(negedge clk) disable iff (!rst_n)
        data_sram_en == (req.valid && req_ok))
        else note_failure("data_sram_en does not follow a valid aligned request");
    a_sram_wen: assert property (@(negedge clk) disable iff (!rst_n)
        data_sram_wen == exp_wen)
        else log_mismatch("data_sram_wen", 32'(exp_wen), 32'(data_sram_wen));
    a_sram_wdata: assert property (@(negedge clk) disable iff (!rst_n)
        req.valid && req.is_store && req_ok |-> data_sram_wdata == placed_data(req))
        else log_mismatch("data_sram_wdata", placed_data(req), data_sram_wdata);
    a_sram_addr: assert property (@(negedge clk) disable iff (!rst_n)
        req.valid && req_ok |-> data_sram_addr == mapped(req.addr))
        else log_mismatch("data_sram_addr", mapped(req.addr), data_sram_addr);
    a_rf_wen: assert property (@(negedge clk) disable iff (!rst_n)
        wb_rf_wen == prev_load)
        else note_failure("wb_rf_wen does not match the load of the previous cycle");
    a_rf_wnum: assert property (@(negedge clk) disable iff (!rst_n)
        prev_load |-> wb_rf_wnum == prev_req.rd)
        else log_mismatch("wb_rf_wnum", 32'(prev_req.rd), 32'(wb_rf_wnum));
    a_rf_wdata: assert property (@(negedge clk) disable iff (!rst_n)
        prev_load |-> wb_rf_wdata == exp_load)
        else log_mismatch("wb_rf_wdata", exp_load, wb_rf_wdata);
    a_exc: assert property (@(negedge clk) disable iff (!rst_n)
        wb_exc == prev_fault)
        else note_failure("wb_exc does not match a misaligned access one cycle earlier");
    a_exc_code: assert property (@(negedge clk) disable iff (!rst_n)
        prev_fault |-> wb_exc_code == exp_code)
        else log_mismatch("wb_exc_code", 32'(exp_code), 32'(wb_exc_code));
    a_bad_addr: assert property (@(negedge clk) disable iff (!rst_n)
        prev_fault |-> wb_bad_addr == prev_req.addr)
        else log_mismatch("wb_bad_addr", prev_req.addr, wb_bad_addr);

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: stimulus still running after %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial
    begin
        lsu_req_t r;
        clk       = 1'b0;
        rst_n     = 1'b0;
        prev_req  = '0;
        exp_load  = '0;
        next_load = '0;
        void'($urandom(32'h0024_c979));
        // faulting load held during reset, must not reach write-back
        req = make_req(1'b0, MEM_WORD, 1'b0, pool_addr(0, 2), 32'h0);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        req   = '0;
        send('0);  // idle, write-back must stay quiet
        test_name = "fill";
        for (int w = 0; w < 16; w++)
            send(make_req(1'b1, MEM_WORD, 1'b0, pool_addr(w, 0), $urandom));
        test_name = "store_load";
        for (int w = 0; w < 4; w++)
        begin
            for (int o = 0; o < 4; o++)
            begin
                send(make_req(1'b1, MEM_BYTE, 1'b0, pool_addr(w, o), $urandom));
                send(make_req(1'b0, MEM_BYTE, o[0], pool_addr(w, o), 32'h0)); // next cycle
            end
            for (int o = 0; o < 4; o += 2)
            begin
                send(make_req(1'b1, MEM_HALF, 1'b0, pool_addr(w, o), $urandom));
                send(make_req(1'b0, MEM_HALF, 1'b0, pool_addr(w, o), 32'h0));
                send(make_req(1'b0, MEM_HALF, 1'b1, pool_addr(w, o), 32'h0));
            end
            send(make_req(1'b0, MEM_WORD, 1'b0, pool_addr(w, 0), 32'h0));
        end
        test_name = "misaligned";
        for (int o = 1; o < 4; o++)
        begin
            send(make_req(1'b0, MEM_WORD, 1'b0, pool_addr(o, o), 32'h0));
            send(make_req(1'b1, MEM_WORD, 1'b0, pool_addr(o, o), $urandom));
            if (o != 2)
            begin
                send(make_req(1'b0, MEM_HALF, 1'b1, pool_addr(o, o), 32'h0));
                send(make_req(1'b1, MEM_HALF, 1'b0, pool_addr(o, o), $urandom));
            end
        end
        test_name = "random";
        for (int n = 0; n < N_RAND; n++)
        begin
            r = make_req(1'($urandom), mem_size_e'(2'($urandom_range(2, 0))), 1'($urandom),
                         pool_addr($urandom_range(15, 0), $urandom_range(3, 0)), $urandom);
            r.valid = ($urandom_range(7, 0) != 0);  // occasional bubble
            send(r);
        end
        send('0);
        send('0);
        @(negedge clk);
        $display("done: %0d requests, %0d mismatches, %0d other errors",
                 n_req, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/lsu_pkg.sv
source/mem_access.sv
source/load_extract.sv
source/lsu_top.sv
verification/tb_sram_model.sv
verification/tb_lsu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the load/store unit testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_lsu
OBJ_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
    -f src.f --top-module "$TOP" --Mdir "$OBJ_DIR"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$("./$OBJ_DIR/V$TOP")
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" <<< "$output"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation did not report a pass"
exit 1
